//--- common/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

	localparam int CMD_BITS = 5;
	localparam int ARGS_BITS = 3;
	localparam int MAX_ARGS = 8;
	localparam int PARAM_BITS = 3;
	localparam int MAX_PARAMS = 8;

	// Numbering follows the host protocol
	typedef enum logic [CMD_BITS-1:0] {
		op_get_version = 5'd0,
		op_get_time = 5'd2,
		op_set_digital_out = 5'd15,
		op_shutdown = 5'd19
	} opcode_t;

	typedef enum logic [1:0] {
		unit_none,
		unit_system,
		unit_gpio
	} unit_t;

	typedef enum logic [7:0] {
		rsp_get_version = 8'd0,
		rsp_get_time = 8'd1
	} rsp_id_t;

	typedef struct packed {
		unit_t unit;
		logic [ARGS_BITS-1:0] nargs;
		logic has_response;
	} cmd_entry_t;

	function automatic cmd_entry_t cmd_lookup(input opcode_t op);
		cmd_entry_t e;
		e.unit = unit_none;
		e.nargs = '0;
		e.has_response = 1'b0;
		case (op)
			op_get_version, op_get_time: begin
				e.unit = unit_system;
				e.has_response = 1'b1;
			end
			op_shutdown: e.unit = unit_system;
			op_set_digital_out: begin
				e.unit = unit_gpio;
				e.nargs = 3'd2;
			end
			// Unknown opcodes are swallowed without arguments
			default: ;
		endcase
		return e;
	endfunction

endpackage

`default_nettype wire

//--- verilog/cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	output logic msg_rd_en,
	input wire busy,
	output logic arg_wr,
	output logic [cmd_pkg::ARGS_BITS-1:0] arg_idx,
	output logic [31:0] arg_value,
	output logic cmd_valid,
	output cmd_pkg::opcode_t cmd_op,
	output cmd_pkg::cmd_entry_t cmd_entry
);

	typedef enum logic [1:0] {
		st_idle,
		st_arg_start,
		st_arg_cont,
		st_arg_end
	} state_t;

	state_t state;
	cmd_pkg::cmd_entry_t lookup;

	always_comb begin
		lookup = cmd_pkg::cmd_lookup(cmd_pkg::opcode_t'(msg_data[cmd_pkg::CMD_BITS-1:0]));
	end

	// A byte is consumed at the end of the cycle in which msg_rd_en is high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			msg_rd_en <= 1'b0;
			arg_wr <= 1'b0;
			arg_idx <= '0;
			cmd_valid <= 1'b0;
			cmd_op <= cmd_pkg::op_get_version;
			cmd_entry <= '0;
		end else begin
			msg_rd_en <= 1'b0;
			arg_wr <= 1'b0;
			cmd_valid <= 1'b0;
			if (msg_rd_en) begin
				case (state)
					st_idle: begin
						cmd_op <= cmd_pkg::opcode_t'(msg_data[cmd_pkg::CMD_BITS-1:0]);
						cmd_entry <= lookup;
						arg_idx <= '0;
						if (lookup.nargs == '0)
							cmd_valid <= 1'b1;
						else
							state <= st_arg_start;
					end
					st_arg_start, st_arg_cont: begin
						if (msg_data[7]) begin
							state <= st_arg_cont;
						end else begin
							arg_wr <= 1'b1;
							state <= st_arg_end;
						end
					end
					default: ;
				endcase
			end else if (state == st_arg_end) begin
				if (arg_idx + 1'b1 == cmd_entry.nargs) begin
					cmd_valid <= 1'b1;
					state <= st_idle;
				end else begin
					arg_idx <= arg_idx + 1'b1;
					state <= st_arg_start;
				end
			end else if (msg_ready && !busy && !cmd_valid) begin
				msg_rd_en <= 1'b1;
			end
		end
	end

	// Bits 6 and 5 of the first byte give the sign of the VLQ argument
	always_ff @(posedge clk) begin
		if (msg_rd_en) begin
			if (state == st_arg_start)
				arg_value <= {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
			else if (state == st_arg_cont)
				arg_value <= {arg_value[24:0], msg_data[6:0]};
		end
	end

endmodule

`default_nettype wire

//--- verilog/cmd_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_dispatch (
	input wire clk,
	input wire rst_n,
	input wire arg_wr,
	input wire [cmd_pkg::ARGS_BITS-1:0] arg_idx,
	input wire [31:0] arg_value,
	input wire cmd_valid,
	input wire cmd_pkg::opcode_t cmd_op,
	input wire cmd_pkg::cmd_entry_t cmd_entry,
	output logic busy,
	output cmd_pkg::opcode_t cmd,
	output logic [31:0] arg_data,
	output logic sys_cmd_ready,
	output logic gpio_cmd_ready,
	input wire sys_arg_advance,
	input wire gpio_arg_advance,
	input wire [31:0] sys_param_data,
	input wire [31:0] gpio_param_data,
	input wire sys_param_write,
	input wire gpio_param_write,
	input wire sys_cmd_done,
	input wire gpio_cmd_done,
	output logic prm_wr,
	output logic [31:0] prm_data,
	output logic rsp_start,
	output cmd_pkg::rsp_id_t rsp_id,
	input wire rsp_done
);

	typedef enum logic [1:0] {
		ds_idle,
		ds_start,
		ds_run,
		ds_rsp
	} state_t;

	state_t state;
	cmd_pkg::unit_t unit;
	logic has_response;
	logic [31:0] args [cmd_pkg::MAX_ARGS];
	logic [cmd_pkg::ARGS_BITS-1:0] arg_ptr;
	logic u_advance;
	logic u_param_write;
	logic u_done;
	logic [31:0] u_param_data;

	always_comb begin
		u_advance = 1'b0;
		u_param_write = 1'b0;
		u_done = 1'b0;
		u_param_data = 32'd0;
		case (unit)
			cmd_pkg::unit_system: begin
				u_advance = sys_arg_advance;
				u_param_write = sys_param_write;
				u_done = sys_cmd_done;
				u_param_data = sys_param_data;
			end
			cmd_pkg::unit_gpio: begin
				u_advance = gpio_arg_advance;
				u_param_write = gpio_param_write;
				u_done = gpio_cmd_done;
				u_param_data = gpio_param_data;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ds_idle;
			busy <= 1'b0;
			cmd <= cmd_pkg::op_get_version;
			unit <= cmd_pkg::unit_none;
			has_response <= 1'b0;
			sys_cmd_ready <= 1'b0;
			gpio_cmd_ready <= 1'b0;
			prm_wr <= 1'b0;
			rsp_start <= 1'b0;
		end else begin
			sys_cmd_ready <= 1'b0;
			gpio_cmd_ready <= 1'b0;
			prm_wr <= 1'b0;
			rsp_start <= 1'b0;
			case (state)
				ds_idle: begin
					if (cmd_valid) begin
						cmd <= cmd_op;
						unit <= cmd_entry.unit;
						has_response <= cmd_entry.has_response;
						busy <= 1'b1;
						state <= ds_start;
					end
				end
				ds_start: begin
					if (unit == cmd_pkg::unit_none) begin
						busy <= 1'b0;
						state <= ds_idle;
					end else begin
						sys_cmd_ready <= (unit == cmd_pkg::unit_system);
						gpio_cmd_ready <= (unit == cmd_pkg::unit_gpio);
						state <= ds_run;
					end
				end
				ds_run: begin
					prm_wr <= u_param_write;
					if (u_done) begin
						if (has_response) begin
							rsp_start <= 1'b1;
							state <= ds_rsp;
						end else begin
							busy <= 1'b0;
							state <= ds_idle;
						end
					end
				end
				ds_rsp: begin
					if (rsp_done) begin
						busy <= 1'b0;
						state <= ds_idle;
					end
				end
			endcase
		end
	end

	// Argument store and the pointer streamed to the unit
	always_ff @(posedge clk) begin
		if (arg_wr)
			args[arg_idx] <= arg_value;
		if (state == ds_start) begin
			arg_data <= args[0];
			arg_ptr <= 1'b1;
		end else if (u_advance) begin
			arg_data <= args[arg_ptr];
			arg_ptr <= arg_ptr + 1'b1;
		end
		prm_data <= u_param_data;
		if (u_done)
			rsp_id <= cmd_pkg::rsp_id_t'(u_param_data[7:0]);
	end

endmodule

`default_nettype wire

//--- verilog/sys_unit.sv
`timescale 1ns/1ns
`default_nettype none

module sys_unit #(
	parameter logic [31:0] VERSION = 32'h0
) (
	input wire clk,
	input wire rst_n,
	input wire cmd_pkg::opcode_t cmd,
	input wire cmd_ready,
	input wire [31:0] arg_data,
	output logic arg_advance,
	output logic [31:0] param_data,
	output logic param_write,
	output logic cmd_done,
	input wire [63:0] systime,
	output logic shutdown
);

	typedef enum logic [1:0] {
		ss_idle,
		ss_time_hi,
		ss_done
	} state_t;

	state_t state;
	logic [31:0] time_hi;

	// No system command takes arguments
	assign arg_advance = 1'b0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ss_idle;
			param_write <= 1'b0;
			cmd_done <= 1'b0;
			shutdown <= 1'b0;
		end else begin
			param_write <= 1'b0;
			cmd_done <= 1'b0;
			case (state)
				ss_idle: begin
					if (cmd_ready) begin
						case (cmd)
							cmd_pkg::op_get_version: begin
								param_write <= 1'b1;
								state <= ss_done;
							end
							cmd_pkg::op_get_time: begin
								param_write <= 1'b1;
								state <= ss_time_hi;
							end
							cmd_pkg::op_shutdown: begin
								shutdown <= 1'b1;
								cmd_done <= 1'b1;
							end
							default: cmd_done <= 1'b1;
						endcase
					end
				end
				ss_time_hi: begin
					param_write <= 1'b1;
					state <= ss_done;
				end
				ss_done: begin
					cmd_done <= 1'b1;
					state <= ss_idle;
				end
				default: state <= ss_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_ready)
			time_hi <= systime[63:32];
		if (state == ss_idle && cmd_ready)
			param_data <= (cmd == cmd_pkg::op_get_time) ? systime[31:0] : VERSION;
		else if (state == ss_time_hi)
			param_data <= time_hi;
		else if (state == ss_done)
			param_data <= {24'd0, (cmd == cmd_pkg::op_get_time) ?
				cmd_pkg::rsp_get_time : cmd_pkg::rsp_get_version};
	end

endmodule

`default_nettype wire

//--- verilog/gpio_unit.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_unit #(
	parameter int NGPIO = 8
) (
	input wire clk,
	input wire rst_n,
	input wire cmd_ready,
	input wire [31:0] arg_data,
	output logic arg_advance,
	output logic cmd_done,
	input wire shutdown,
	output logic [NGPIO-1:0] gpio
);

	typedef enum logic [1:0] {
		gs_idle,
		gs_wait,
		gs_apply
	} state_t;

	state_t state;
	logic [31:0] chan;

	// Channel arrives with cmd_ready, value two cycles later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= gs_idle;
			arg_advance <= 1'b0;
			cmd_done <= 1'b0;
			gpio <= '0;
		end else begin
			arg_advance <= 1'b0;
			cmd_done <= 1'b0;
			case (state)
				gs_idle: begin
					if (cmd_ready) begin
						arg_advance <= 1'b1;
						state <= gs_wait;
					end
				end
				gs_wait: state <= gs_apply;
				gs_apply: begin
					if (!shutdown && chan < NGPIO)
						gpio[chan] <= arg_data[0];
					cmd_done <= 1'b1;
					state <= gs_idle;
				end
				default: state <= gs_idle;
			endcase
			if (shutdown)
				gpio <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == gs_idle && cmd_ready)
			chan <= arg_data;
	end

endmodule

`default_nettype wire

//--- verilog/rsp_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module rsp_encoder #(
	parameter int LEN_BITS = 8
) (
	input wire clk,
	input wire rst_n,
	input wire prm_wr,
	input wire [31:0] prm_data,
	input wire rsp_start,
	input wire cmd_pkg::rsp_id_t rsp_id,
	output logic rsp_done,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	input wire send_ring_full,
	output logic [LEN_BITS-1:0] send_fifo_data,
	output logic send_fifo_wr_en
);

	typedef enum logic [1:0] {
		es_idle,
		es_id,
		es_skip,
		es_send
	} state_t;

	state_t state;
	logic [31:0] params [cmd_pkg::MAX_PARAMS];
	logic [cmd_pkg::PARAM_BITS-1:0] nparams;
	logic [cmd_pkg::PARAM_BITS-1:0] cur;
	logic [31:0] next_param;
	logic [34:0] shift;
	logic [2:0] cnt;
	logic [LEN_BITS-1:0] len;
	logic out_valid;
	logic last;
	logic stall;
	logic can_skip;

	// send_ring_data is a one-byte slot, emptied whenever the ring accepts it
	assign send_ring_wr_en = out_valid && !send_ring_full;
	assign stall = out_valid && send_ring_full;
	assign next_param = params[cur + 1'b1];
	// Leading group is pure sign extension of the group below it
	assign can_skip = cnt != 3'd1 && (shift[34:26] == 9'h1ff || shift[34:26] < 9'd3);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= es_idle;
			nparams <= '0;
			cur <= '0;
			cnt <= 3'd0;
			len <= '0;
			out_valid <= 1'b0;
			last <= 1'b0;
			rsp_done <= 1'b0;
			send_fifo_wr_en <= 1'b0;
		end else begin
			rsp_done <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			if (send_ring_wr_en) begin
				out_valid <= 1'b0;
				if (last) begin
					last <= 1'b0;
					nparams <= '0;
					send_fifo_wr_en <= 1'b1;
					rsp_done <= 1'b1;
				end
			end
			if (prm_wr)
				nparams <= nparams + 1'b1;
			case (state)
				es_idle: begin
					if (rsp_start)
						state <= es_id;
				end
				es_id: begin
					if (!stall) begin
						out_valid <= 1'b1;
						len <= 1'b1;
						cur <= '0;
						cnt <= 3'd5;
						if (nparams == '0) begin
							last <= 1'b1;
							state <= es_idle;
						end else begin
							state <= es_skip;
						end
					end
				end
				es_skip: begin
					if (can_skip)
						cnt <= cnt - 1'b1;
					else
						state <= es_send;
				end
				es_send: begin
					if (!stall) begin
						out_valid <= 1'b1;
						len <= len + 1'b1;
						cnt <= cnt - 1'b1;
						if (cnt == 3'd1) begin
							if (cur + 1'b1 != nparams) begin
								cur <= cur + 1'b1;
								cnt <= 3'd5;
								state <= es_skip;
							end else begin
								last <= 1'b1;
								state <= es_idle;
							end
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (prm_wr)
			params[nparams] <= prm_data;
		case (state)
			es_id: begin
				if (!stall) begin
					send_ring_data <= rsp_id;
					shift <= {{3{params[0][31]}}, params[0]};
				end
			end
			es_skip: begin
				if (can_skip)
					shift <= {shift[27:0], 7'd0};
			end
			es_send: begin
				if (!stall) begin
					send_ring_data <= {cnt != 3'd1, shift[34:28]};
					if (cnt == 3'd1)
						shift <= {{3{next_param[31]}}, next_param};
					else
						shift <= {shift[27:0], 7'd0};
				end
			end
			default: ;
		endcase
		if (send_ring_wr_en && last)
			send_fifo_data <= len;
	end

endmodule

`default_nettype wire

//--- verilog/command.sv
`timescale 1ns/1ns
`default_nettype none

module command #(
	parameter logic [31:0] VERSION = 32'h0,
	parameter int NGPIO = 8,
	parameter int LEN_BITS = 8
) (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	output wire msg_rd_en,
	output wire [7:0] send_ring_data,
	output wire send_ring_wr_en,
	input wire send_ring_full,
	output wire [LEN_BITS-1:0] send_fifo_data,
	output wire send_fifo_wr_en,
	// Frame lengths are written after the frame, the host sizes this fifo
	input wire send_fifo_full,
	input wire [63:0] systime,
	output wire [NGPIO-1:0] gpio
);

	wire arg_wr;
	wire [cmd_pkg::ARGS_BITS-1:0] arg_idx;
	wire [31:0] arg_value;
	wire cmd_valid;
	cmd_pkg::opcode_t cmd_op;
	cmd_pkg::cmd_entry_t cmd_entry;
	wire busy;
	cmd_pkg::opcode_t cmd;
	wire [31:0] arg_data;
	wire sys_cmd_ready;
	wire gpio_cmd_ready;
	wire sys_arg_advance;
	wire gpio_arg_advance;
	wire [31:0] sys_param_data;
	wire sys_param_write;
	wire sys_cmd_done;
	wire gpio_cmd_done;
	wire shutdown;
	wire prm_wr;
	wire [31:0] prm_data;
	wire rsp_start;
	cmd_pkg::rsp_id_t rsp_id;
	wire rsp_done;

	cmd_decoder u_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.busy(busy),
		.arg_wr(arg_wr),
		.arg_idx(arg_idx),
		.arg_value(arg_value),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_entry(cmd_entry)
	);

	// GPIO writes return no parameters
	cmd_dispatch u_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.arg_wr(arg_wr),
		.arg_idx(arg_idx),
		.arg_value(arg_value),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_entry(cmd_entry),
		.busy(busy),
		.cmd(cmd),
		.arg_data(arg_data),
		.sys_cmd_ready(sys_cmd_ready),
		.gpio_cmd_ready(gpio_cmd_ready),
		.sys_arg_advance(sys_arg_advance),
		.gpio_arg_advance(gpio_arg_advance),
		.sys_param_data(sys_param_data),
		.gpio_param_data(32'd0),
		.sys_param_write(sys_param_write),
		.gpio_param_write(1'b0),
		.sys_cmd_done(sys_cmd_done),
		.gpio_cmd_done(gpio_cmd_done),
		.prm_wr(prm_wr),
		.prm_data(prm_data),
		.rsp_start(rsp_start),
		.rsp_id(rsp_id),
		.rsp_done(rsp_done)
	);

	sys_unit #(
		.VERSION(VERSION)
	) u_sys (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.cmd_ready(sys_cmd_ready),
		.arg_data(arg_data),
		.arg_advance(sys_arg_advance),
		.param_data(sys_param_data),
		.param_write(sys_param_write),
		.cmd_done(sys_cmd_done),
		.systime(systime),
		.shutdown(shutdown)
	);

	gpio_unit #(
		.NGPIO(NGPIO)
	) u_gpio (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_ready(gpio_cmd_ready),
		.arg_data(arg_data),
		.arg_advance(gpio_arg_advance),
		.cmd_done(gpio_cmd_done),
		.shutdown(shutdown),
		.gpio(gpio)
	);

	rsp_encoder #(
		.LEN_BITS(LEN_BITS)
	) u_encoder (
		.clk(clk),
		.rst_n(rst_n),
		.prm_wr(prm_wr),
		.prm_data(prm_data),
		.rsp_start(rsp_start),
		.rsp_id(rsp_id),
		.rsp_done(rsp_done),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en)
	);

endmodule

`default_nettype wire

//--- sim/command_tb.sv
`timescale 1ns/1ns
`default_nettype none

module command_tb;

	localparam logic [31:0] VERSION = 32'h0001_0203;
	localparam int NGPIO = 8;
	localparam int LEN_BITS = 8;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic [7:0] msg_data = 8'd0;
	logic msg_ready = 1'b0;
	logic send_ring_full = 1'b0;
	logic send_fifo_full = 1'b0;
	logic [63:0] systime = 64'd0;
	wire msg_rd_en;
	wire [7:0] send_ring_data;
	wire send_ring_wr_en;
	wire [LEN_BITS-1:0] send_fifo_data;
	wire send_fifo_wr_en;
	wire [NGPIO-1:0] gpio;

	logic [7:0] ring_q [$];
	logic [LEN_BITS-1:0] len_q [$];
	logic [NGPIO-1:0] gpio_ref = '0;
	logic shut_ref = 1'b0;
	logic stall_en = 1'b0;
	logic [2:0] stall_span = 3'd0;
	logic [31:0] rng = 32'hecd;
	int checks = 0;
	int errors = 0;

	// Pairs of low and high words, both sides of each VLQ length boundary
	logic [31:0] time_words [18] = '{
		32'd0, 32'd95, 32'd96, -32'sd32, -32'sd33, 32'd12287,
		32'd12288, -32'sd4096, -32'sd4097, 32'd1572863, 32'd1572864, -32'sd524288,
		-32'sd524289, 32'd201326591, 32'd201326592, -32'sd67108864, -32'sd67108865,
		32'h8000_0000
	};

	command #(
		.VERSION(VERSION),
		.NGPIO(NGPIO),
		.LEN_BITS(LEN_BITS)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en),
		.send_fifo_full(send_fifo_full),
		.systime(systime),
		.gpio(gpio)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (send_ring_wr_en)
			ring_q.push_back(send_ring_data);
		if (send_fifo_wr_en)
			len_q.push_back(send_fifo_data);
	end

	// Ring back-pressure in random spans
	always @(negedge clk) begin
		if (!stall_en) begin
			send_ring_full = 1'b0;
		end else if (stall_span == 3'd0) begin
			rng = xorshift(rng);
			send_ring_full = rng[0];
			stall_span = rng[3:1];
		end else begin
			stall_span = stall_span - 3'd1;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int vlq_len(input logic signed [31:0] v);
		if (v >= -32 && v <= 95)
			return 1;
		else if (v >= -4096 && v <= 12287)
			return 2;
		else if (v >= -524288 && v <= 1572863)
			return 3;
		else if (v >= -67108864 && v <= 201326591)
			return 4;
		return 5;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
		$display("%0d checks, %0d errors", checks, errors);
		$display("Test FAILED");
		$finish;
	endtask

	// Called on a falling edge, returns on the falling edge after the byte is taken
	task automatic send_byte(input logic [7:0] b);
		int t;
		t = 0;
		msg_data = b;
		msg_ready = 1'b1;
		@(negedge clk);
		while (!msg_rd_en) begin
			t++;
			if (t > 100)
				abort_on_timeout("msg_rd_en");
			@(negedge clk);
		end
		@(negedge clk);
		msg_ready = 1'b0;
	endtask

	// Optional pad adds a redundant leading sign group
	task automatic send_arg(input logic signed [31:0] v, input bit pad);
		int n;
		int i;
		n = vlq_len(v);
		if (pad)
			send_byte(v[31] ? 8'hff : 8'h80);
		for (i = n - 1; i >= 0; i--)
			send_byte({i != 0, 7'(v >>> (7 * i))});
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (!DUT.busy) begin
			@(negedge clk);
			t++;
			if (t > 20)
				abort_on_timeout("busy to rise");
		end
		t = 0;
		while (DUT.busy) begin
			@(negedge clk);
			t++;
			if (t > 500)
				abort_on_timeout("busy to fall");
		end
	endtask

	task automatic run_cmd(input logic [7:0] op, input int nargs, input logic [31:0] a0,
			input logic [31:0] a1, input bit pad);
		send_byte(op);
		if (nargs > 0)
			send_arg(a0, pad);
		if (nargs > 1)
			send_arg(a1, pad);
		wait_idle();
	endtask

	// Decodes the captured frame and compares every parameter and the length word
	task automatic check_frame(input string name, input logic [7:0] id, input int np,
			input logic [31:0] p0, input logic [31:0] p1);
		int pos;
		int n;
		int k;
		logic [31:0] v;
		logic [31:0] exp;
		check_value({name, " length writes"}, 1, len_q.size());
		check_value({name, " id"}, id, ring_q[0]);
		pos = 1;
		for (k = 0; k < np; k++) begin
			exp = (k == 0) ? p0 : p1;
			v = {32{ring_q[pos][6] & ring_q[pos][5]}};
			n = 0;
			while (pos < ring_q.size() && (n == 0 || ring_q[pos - 1][7])) begin
				v = {v[24:0], ring_q[pos][6:0]};
				pos++;
				n++;
			end
			check_value({name, " value"}, exp, v);
			check_value({name, " bytes"}, vlq_len(exp), n);
		end
		check_value({name, " frame size"}, pos, ring_q.size());
		if (len_q.size() > 0)
			check_value({name, " fifo length"}, ring_q.size(), len_q[0]);
		ring_q.delete();
		len_q.delete();
	endtask

	task automatic read_version(input string name);
		run_cmd(8'd0, 0, 32'd0, 32'd0, 1'b0);
		check_frame(name, 8'd0, 1, VERSION, 32'd0);
	endtask

	task automatic read_time(input string name, input logic [63:0] t);
		systime = t;
		run_cmd(8'd2, 0, 32'd0, 32'd0, 1'b0);
		check_frame(name, 8'd1, 2, t[31:0], t[63:32]);
	endtask

	task automatic write_output(input logic [31:0] chan, input logic [31:0] val, input bit pad);
		run_cmd(8'd15, 2, chan, val, pad);
		if (!shut_ref && chan < NGPIO)
			gpio_ref[chan] = val[0];
		check_value("set_digital_out gpio", gpio_ref, gpio);
		check_value("set_digital_out frames", 0, ring_q.size() + len_q.size());
	endtask

	task automatic run_unused(input logic [7:0] op);
		run_cmd(op, 0, 32'd0, 32'd0, 1'b0);
		check_value("unused opcode gpio", gpio_ref, gpio);
		check_value("unused opcode frames", 0, ring_q.size() + len_q.size());
	endtask

	initial begin
		int i;
		logic [31:0] r;
		logic [31:0] lo;
		logic [31:0] hi;
		logic [7:0] op;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_value("reset gpio", 0, gpio);
		check_value("reset msg_rd_en", 0, msg_rd_en);
		@(negedge clk);

		read_version("get_version");
		for (i = 0; i < 18; i += 2)
			read_time("get_time", {time_words[i + 1], time_words[i]});

		write_output(32'd3, 32'd1, 1'b1);
		write_output(32'd7, -32'sd1, 1'b0);
		write_output(32'd0, 32'd201, 1'b1);
		write_output(32'd3, -32'sd4096, 1'b0);
		write_output(-32'sd1, 32'd1, 1'b0);
		write_output(32'd100, 32'd1, 1'b1);
		write_output(32'd8, 32'd1, 1'b0);

		for (i = 0; i < 40; i++) begin
			rng = xorshift(rng);
			r = rng;
			case (r[1:0])
				2'd0: begin
					rng = xorshift(rng);
					write_output({28'd0, r[5:2]}, $signed(rng) >>> r[12:8], r[7]);
				end
				2'd1: read_version("random get_version");
				2'd2: begin
					rng = xorshift(rng);
					lo = $signed(rng) >>> r[12:8];
					rng = xorshift(rng);
					hi = $signed(rng) >>> r[17:13];
					read_time("random get_time", {hi, lo});
				end
				default: begin
					op = {3'd0, r[12:8]};
					if (op == 8'd0 || op == 8'd2 || op == 8'd15 || op == 8'd19)
						op = 8'd1;
					run_unused(op);
				end
			endcase
		end

		stall_en = 1'b1;
		for (i = 4; i < 18; i += 6)
			read_time("get_time with ring full", {time_words[i + 1], time_words[i]});
		stall_en = 1'b0;
		@(negedge clk);

		write_output(32'd5, 32'd1, 1'b0);
		run_cmd(8'd19, 0, 32'd0, 32'd0, 1'b0);
		shut_ref = 1'b1;
		gpio_ref = '0;
		check_value("shutdown gpio", gpio_ref, gpio);
		check_value("shutdown frames", 0, ring_q.size() + len_q.size());
		write_output(32'd5, 32'd1, 1'b0);
		read_version("get_version after shutdown");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
common/cmd_pkg.sv
verilog/cmd_decoder.sv
verilog/cmd_dispatch.sv
verilog/sys_unit.sv
verilog/gpio_unit.sv
verilog/rsp_encoder.sv
verilog/command.sv
sim/command_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module command_tb -o command_tb \
	&& ./obj_dir/command_tb | tee /dev/stderr | grep -q "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
